//--- hw/perf_cfg.svh
`ifndef PERF_CFG_SVH
`define PERF_CFG_SVH

// Width of every counter
// Also the width of the read data port
`define PERF_CNT_WIDTH 32

// Read address width
// Covers the 23 live counters plus the zero-reading gap up to 31
`define PERF_ADDR_WIDTH 5

`endif

//--- hw/perf_pkg.sv
`default_nettype none

package perf_pkg;

  // Per-cycle core levels, sampled with no handshake
  typedef struct packed {
    logic instret;
    logic icache_valid;
    logic icache_ready;
    logic dcache_valid;
    logic dcache_ready;
    logic br_override;
    logic fe_cmd;
    logic mispredict;
    logic control_haz;
    logic data_haz;
    logic struct_haz;
    logic dc_miss;
  } perf_core_stat_s;

  // L2 levels, single bank
  typedef struct packed {
    logic l2_cmd_v;
    logic l2_serving_ic;
    logic l2_serving_dc;
    logic l2_serving_evict;
  } perf_mem_stat_s;

  // Stall reasons, highest priority first
  typedef enum logic [3:0] {
    stall_ic_miss     = 4'd0,
    stall_br_override = 4'd1,
    stall_fe_cmd      = 4'd2,
    stall_mispredict  = 4'd3,
    stall_control_haz = 4'd4,
    stall_data_haz    = 4'd5,
    stall_struct_haz  = 4'd6,
    stall_dc_miss     = 4'd7,
    stall_unknown     = 4'd8
  } perf_stall_e;

  localparam int PERF_STALL_REASONS = 9;

  // Fields listed MSB first, so mcycle sits on bit 0
  // stall[] is indexed by perf_stall_e
  // Counter index equals bit position
  typedef struct packed {
    logic [PERF_STALL_REASONS-1:0] stall;
    logic                          minstret;
    logic                          mcycle;
  } perf_stall_events_s;

  // Same layout rule, ic_req lands on bit 0
  typedef struct packed {
    logic l2_dc_evict_cmd;
    logic l2_dc_fetch_cmd;
    logic l2_ic_cmd;
    logic l2_dc_evict;
    logic l2_dc_fetch;
    logic l2_ic;
    logic dc_miss;
    logic dc_miss_cnt;
    logic dc_req;
    logic ic_miss;
    logic ic_miss_cnt;
    logic ic_req;
  } perf_mem_events_s;

  // Counters per bank
  localparam int PERF_STALL_CNT = $bits(perf_stall_events_s);
  localparam int PERF_MEM_CNT   = $bits(perf_mem_events_s);

endpackage

`default_nettype wire

//--- hw/perf_stall_classifier.sv
`timescale 1ns/1ns
`default_nettype none

module perf_stall_classifier
  import perf_pkg::*;
  (
    input  wire                clk_i,
    input  wire                reset_i,
    input  wire perf_core_stat_s core_stat_i,
    output perf_stall_events_s stall_ev_o
  );

  perf_stall_e                   reason;
  logic [PERF_STALL_REASONS-1:0] reason_oh;

  // Priority chain
  // Front end causes come before back end ones
  always_comb begin
    if (!core_stat_i.icache_ready) begin
      reason = stall_ic_miss;
    end else if (core_stat_i.br_override) begin
      reason = stall_br_override;
    end else if (core_stat_i.fe_cmd) begin
      reason = stall_fe_cmd;
    end else if (core_stat_i.mispredict) begin
      reason = stall_mispredict;
    end else if (core_stat_i.control_haz) begin
      reason = stall_control_haz;
    end else if (core_stat_i.data_haz) begin
      reason = stall_data_haz;
    end else if (core_stat_i.struct_haz) begin
      reason = stall_struct_haz;
    end else if (core_stat_i.dc_miss) begin
      reason = stall_dc_miss;
    end else begin
      // Nothing explains the bubble
      reason = stall_unknown;
    end
  end

  // One-hot expansion of the winning reason
  assign reason_oh = PERF_STALL_REASONS'(1) << reason;

  // Every cycle counts toward mcycle
  assign stall_ev_o.mcycle   = 1'b1;
  assign stall_ev_o.minstret = core_stat_i.instret;
  // Stall credit only on non-retiring cycles
  assign stall_ev_o.stall    = core_stat_i.instret ? '0 : reason_oh;

  // Stall bits stay exclusive and retiring cycles are never blamed on a stall
  a_stall_exclusive: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $onehot0(stall_ev_o.stall) && !(stall_ev_o.minstret && |stall_ev_o.stall)
  ) else $error("stall classifier: bad stall vector %b", stall_ev_o.stall);

endmodule

`default_nettype wire

//--- hw/perf_mem_event_detect.sv
`timescale 1ns/1ns
`default_nettype none

module perf_mem_event_detect
  import perf_pkg::*;
  (
    input  wire                clk_i,
    input  wire                reset_i,
    input  wire perf_core_stat_s core_stat_i,
    input  wire perf_mem_stat_s  mem_stat_i,
    output perf_mem_events_s   mem_ev_o
  );

  // Ready levels from the previous cycle
  logic ic_ready_q;
  logic dc_ready_q;

  // L2 service class, before the command strobe
  logic l2_ic_v;
  logic l2_dc_fetch_v;
  logic l2_dc_evict_v;

  // Reset to ready so no false miss edge shows up
  // Runs regardless of en_i
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ic_ready_q <= 1'b1;
      dc_ready_q <= 1'b1;
    end else begin
      ic_ready_q <= core_stat_i.icache_ready;
      dc_ready_q <= core_stat_i.dcache_ready;
    end
  end

  // I$ requests accepted
  assign mem_ev_o.ic_req      = core_stat_i.icache_valid & core_stat_i.icache_ready;
  // Falling edge of ready starts a miss
  assign mem_ev_o.ic_miss_cnt = ~core_stat_i.icache_ready & ic_ready_q;
  // Cycles spent in a miss
  assign mem_ev_o.ic_miss     = ~core_stat_i.icache_ready;

  // D$ mirrors the I$ rules
  assign mem_ev_o.dc_req      = core_stat_i.dcache_valid & core_stat_i.dcache_ready;
  assign mem_ev_o.dc_miss_cnt = ~core_stat_i.dcache_ready & dc_ready_q;
  assign mem_ev_o.dc_miss     = ~core_stat_i.dcache_ready;

  // Who the L2 is working for
  assign l2_ic_v       = mem_stat_i.l2_serving_ic;
  assign l2_dc_fetch_v = mem_stat_i.l2_serving_dc & ~mem_stat_i.l2_serving_evict;
  assign l2_dc_evict_v = mem_stat_i.l2_serving_dc & mem_stat_i.l2_serving_evict;

  // Serving cycles
  assign mem_ev_o.l2_ic       = l2_ic_v;
  assign mem_ev_o.l2_dc_fetch = l2_dc_fetch_v;
  assign mem_ev_o.l2_dc_evict = l2_dc_evict_v;

  // Command strobes, one per L2 transaction
  assign mem_ev_o.l2_ic_cmd       = l2_ic_v & mem_stat_i.l2_cmd_v;
  assign mem_ev_o.l2_dc_fetch_cmd = l2_dc_fetch_v & mem_stat_i.l2_cmd_v;
  assign mem_ev_o.l2_dc_evict_cmd = l2_dc_evict_v & mem_stat_i.l2_cmd_v;

  // Single L2 bank serves one client at a time
  a_l2_one_client: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(mem_stat_i.l2_serving_ic && mem_stat_i.l2_serving_dc)
  ) else $error("mem event detect: L2 serving I$ and D$ together");

endmodule

`default_nettype wire

//--- hw/perf_counter_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "perf_cfg.svh"

module perf_counter_bank
  #(
    parameter type event_t = logic
  )
  (
    input  wire                                             clk_i,
    input  wire                                             reset_i,
    input  wire                                             freeze_i,
    input  wire                                             en_i,
    input  wire event_t                                     event_i,
    output logic [$bits(event_t)-1:0][`PERF_CNT_WIDTH-1:0] count_o
  );

  localparam int num_cnt = $bits(event_t);

  // Flattened event bits, bit i drives counter i
  logic [num_cnt-1:0] ev_bits;
  // Increment strobes after gating
  logic [num_cnt-1:0] inc;

  assign ev_bits = event_i;
  // Clear beats count
  assign inc = (en_i && !freeze_i) ? ev_bits : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i || freeze_i) begin
      count_o <= '0;
    end else begin
      for (int i = 0; i < num_cnt; i++) begin
        if (inc[i]) begin
          count_o[i] <= count_o[i] + 1'b1;
        end
      end
    end
  end

  // Counters wrap silently in hardware
  // An increment must never land on zero
  for (genvar g = 0; g < num_cnt; g++) begin : g_wrap_chk
    a_no_wrap: assert property (
      @(posedge clk_i) disable iff (reset_i || freeze_i)
      inc[g] |=> (count_o[g] != '0)
    ) else $error("counter bank: counter %0d wrapped", g);
  end

endmodule

`default_nettype wire

//--- hw/perf_readout.sv
`timescale 1ns/1ns
`default_nettype none

`include "perf_cfg.svh"

module perf_readout
  import perf_pkg::*;
  (
    input  wire                                         clk_i,
    input  wire                                         reset_i,
    input  wire [`PERF_ADDR_WIDTH-1:0]                  rd_addr_i,
    input  wire [PERF_STALL_CNT-1:0][`PERF_CNT_WIDTH-1:0] stall_cnt_i,
    input  wire [PERF_MEM_CNT-1:0][`PERF_CNT_WIDTH-1:0]   mem_cnt_i,
    output logic [`PERF_CNT_WIDTH-1:0]                  rd_data_o
  );

  localparam int addr_w = `PERF_ADDR_WIDTH;

  // Memory bank starts right after the stall bank
  localparam logic [addr_w-1:0] mem_base = addr_w'(PERF_STALL_CNT);
  localparam logic [addr_w-1:0] mem_end  = addr_w'(PERF_STALL_CNT + PERF_MEM_CNT);

  logic                         in_stall;
  logic                         in_mem;
  logic [addr_w-1:0]            mem_idx;
  logic [`PERF_CNT_WIDTH-1:0]   rd_data_d;

  // Address decode
  assign in_stall = (rd_addr_i < mem_base);
  assign in_mem   = !in_stall && (rd_addr_i < mem_end);
  // Offset into the memory bank
  assign mem_idx  = rd_addr_i - mem_base;

  always_comb begin
    if (in_stall) begin
      rd_data_d = stall_cnt_i[rd_addr_i];
    end else if (in_mem) begin
      rd_data_d = mem_cnt_i[mem_idx];
    end else begin
      // Unmapped range reads zero
      rd_data_d = '0;
    end
  end

  // One cycle read latency
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_data_o <= '0;
    end else begin
      rd_data_o <= rd_data_d;
    end
  end

endmodule

`default_nettype wire

//--- hw/perf_profiler_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "perf_cfg.svh"

module perf_profiler_top
  import perf_pkg::*;
  (
    input  wire                          clk_i,
    input  wire                          reset_i,
    input  wire                          freeze_i,
    input  wire                          en_i,
    input  wire perf_core_stat_s         core_stat_i,
    input  wire perf_mem_stat_s          mem_stat_i,
    input  wire [`PERF_ADDR_WIDTH-1:0]   rd_addr_i,
    output logic [`PERF_CNT_WIDTH-1:0]   rd_data_o
  );

  // Per-cycle event structs
  perf_stall_events_s stall_ev;
  perf_mem_events_s   mem_ev;

  // Live counter values
  logic [PERF_STALL_CNT-1:0][`PERF_CNT_WIDTH-1:0] stall_cnt;
  logic [PERF_MEM_CNT-1:0][`PERF_CNT_WIDTH-1:0]   mem_cnt;

  // Commit side
  perf_stall_classifier u_stall_classifier (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .core_stat_i (core_stat_i),
    .stall_ev_o  (stall_ev)
  );

  // Memory side
  perf_mem_event_detect u_mem_event_detect (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .core_stat_i (core_stat_i),
    .mem_stat_i  (mem_stat_i),
    .mem_ev_o    (mem_ev)
  );

  // Counters 0 to 10
  perf_counter_bank #(
    .event_t (perf_stall_events_s)
  ) bank_stall (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .freeze_i (freeze_i),
    .en_i     (en_i),
    .event_i  (stall_ev),
    .count_o  (stall_cnt)
  );

  // Counters 11 to 22
  perf_counter_bank #(
    .event_t (perf_mem_events_s)
  ) bank_mem (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .freeze_i (freeze_i),
    .en_i     (en_i),
    .event_i  (mem_ev),
    .count_o  (mem_cnt)
  );

  // Single read port over both banks
  perf_readout u_readout (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .rd_addr_i   (rd_addr_i),
    .stall_cnt_i (stall_cnt),
    .mem_cnt_i   (mem_cnt),
    .rd_data_o   (rd_data_o)
  );

endmodule

`default_nettype wire

//--- dv/tb_perf_profiler.sv
`timescale 1ns/1ns
`default_nettype none

`include "perf_cfg.svh"

module tb_perf_profiler
  import perf_pkg::*;
  ();

  localparam int num_cnt    = PERF_STALL_CNT + PERF_MEM_CNT;
  localparam int num_addr   = 1 << `PERF_ADDR_WIDTH;
  localparam int reset_cyc  = 16;
  // Sweep of every address plus worst case idle padding
  localparam int test_cyc   = num_addr + 1 + 4;
  localparam int stall_base = 2;
  localparam int mem_base   = PERF_STALL_CNT;

  // One line of the vector file
  typedef struct packed {
    logic            is_mark;
    logic            freeze;
    logic            en;
    perf_core_stat_s core;
    perf_mem_stat_s  mem;
  } vec_s;

  logic                        clk;
  logic                        reset;
  logic                        freeze;
  logic                        en;
  perf_core_stat_s             core_stat;
  perf_mem_stat_s              mem_stat;
  logic [`PERF_ADDR_WIDTH-1:0] rd_addr;
  logic [`PERF_CNT_WIDTH-1:0]  rd_data;

  // Loaded vectors, names only on marker entries
  vec_s  vec_q[$];
  string name_q[$];

  // Reference counts and the detector's previous ready levels
  logic [`PERF_CNT_WIDTH-1:0] exp_cnt [num_cnt];
  logic                       prev_ic_rdy;
  logic                       prev_dc_rdy;

  int seed         = 19;
  int cycles       = 0;
  int limit        = 1000000;
  int n_tests      = 0;
  int n_stim       = 0;
  int total_checks = 0;
  int total_errs   = 0;
  bit load_ok;

  perf_profiler_top dut (
    .clk_i       (clk),
    .reset_i     (reset),
    .freeze_i    (freeze),
    .en_i        (en),
    .core_stat_i (core_stat),
    .mem_stat_i  (mem_stat),
    .rd_addr_i   (rd_addr),
    .rd_data_o   (rd_data)
  );

  always #50 clk = ~clk;

  // Run limit, set once the vectors are loaded
  always @(posedge clk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout: run reached %0d cycles without finishing", limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // Caches ready, nothing retiring, counting off
  function automatic vec_s idle_vec();
    vec_s v;
    v = '0;
    v.core.icache_ready = 1'b1;
    v.core.dcache_ready = 1'b1;
    return v;
  endfunction

  function automatic logic [`PERF_CNT_WIDTH-1:0] expected_count(int addr);
    // Unmapped addresses read zero
    if (addr < num_cnt) begin
      return exp_cnt[addr];
    end
    return '0;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic clear_model();
    for (int k = 0; k < num_cnt; k++) begin
      exp_cnt[k] = '0;
    end
    // Detector resets to ready
    prev_ic_rdy = 1'b1;
    prev_dc_rdy = 1'b1;
  endtask

  // Effect of one cycle on the counts, applied at the edge that ends it
  task automatic model_cycle(input vec_s v);
    int reason;
    if (v.freeze) begin
      clear_model();
    end else if (v.en) begin
      exp_cnt[0]++;
      if (v.core.instret) begin
        exp_cnt[1]++;
      end else begin
        // Highest priority cause wins
        if (!v.core.icache_ready) reason = 0;
        else if (v.core.br_override) reason = 1;
        else if (v.core.fe_cmd) reason = 2;
        else if (v.core.mispredict) reason = 3;
        else if (v.core.control_haz) reason = 4;
        else if (v.core.data_haz) reason = 5;
        else if (v.core.struct_haz) reason = 6;
        else if (v.core.dc_miss) reason = 7;
        else reason = 8;
        exp_cnt[stall_base + reason]++;
      end
      // Cache requests, miss edges and miss cycles
      if (v.core.icache_valid && v.core.icache_ready) exp_cnt[mem_base + 0]++;
      if (!v.core.icache_ready && prev_ic_rdy) exp_cnt[mem_base + 1]++;
      if (!v.core.icache_ready) exp_cnt[mem_base + 2]++;
      if (v.core.dcache_valid && v.core.dcache_ready) exp_cnt[mem_base + 3]++;
      if (!v.core.dcache_ready && prev_dc_rdy) exp_cnt[mem_base + 4]++;
      if (!v.core.dcache_ready) exp_cnt[mem_base + 5]++;
      // L2 service, command counts only with the strobe
      if (v.mem.l2_serving_ic) begin
        exp_cnt[mem_base + 6]++;
        if (v.mem.l2_cmd_v) exp_cnt[mem_base + 9]++;
      end
      if (v.mem.l2_serving_dc && !v.mem.l2_serving_evict) begin
        exp_cnt[mem_base + 7]++;
        if (v.mem.l2_cmd_v) exp_cnt[mem_base + 10]++;
      end
      if (v.mem.l2_serving_dc && v.mem.l2_serving_evict) begin
        exp_cnt[mem_base + 8]++;
        if (v.mem.l2_cmd_v) exp_cnt[mem_base + 11]++;
      end
    end
    // Ready history moves every cycle, even with en low
    prev_ic_rdy = v.core.icache_ready;
    prev_dc_rdy = v.core.dcache_ready;
  endtask

  task automatic drive_inputs(input vec_s v);
    freeze    = v.freeze;
    en        = v.en;
    core_stat = v.core;
    mem_stat  = v.mem;
  endtask

  task automatic apply(input vec_s v);
    drive_inputs(v);
    model_cycle(v);
  endtask

  task automatic load_vectors(output bit ok);
    int          fd;
    int          n;
    int          bad;
    string       line;
    string       kind;
    string       name;
    logic        fr_b;
    logic        en_b;
    logic [11:0] core_b;
    logic [3:0]  mem_b;
    vec_s        v;
    ok  = 1'b0;
    bad = 0;
    fd  = $fopen("dv/perf_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open dv/perf_vectors.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        kind = "";
        n = $fgets(line, fd);
        if (n > 0) n = $sscanf(line, "%s", kind);
        if (kind == "S") begin
          n = $sscanf(line, "S %b %b %b %b", fr_b, en_b, core_b, mem_b);
          if (n == 4) begin
            v        = '0;
            v.freeze = fr_b;
            v.en     = en_b;
            v.core   = perf_core_stat_s'(core_b);
            v.mem    = perf_mem_stat_s'(mem_b);
            vec_q.push_back(v);
            name_q.push_back("");
            n_stim++;
          end else begin
            $display("malformed stimulus line in vector file: %s", line);
            bad++;
          end
        end else if (kind == "T") begin
          n = $sscanf(line, "T %s", name);
          v = '0;
          v.is_mark = 1'b1;
          vec_q.push_back(v);
          name_q.push_back(name);
          n_tests++;
        end
      end
      $fclose(fd);
      if (n_tests == 0) $display("no tests found in dv/perf_vectors.txt");
      ok = (n_tests > 0) && (bad == 0);
    end
  endtask

  // Sweep all addresses with counting off, one cycle per address
  task automatic check_test(input string name);
    int                         errs;
    int                         a;
    logic [`PERF_CNT_WIDTH-1:0] exp;
    logic [`PERF_CNT_WIDTH-1:0] seen [num_addr];
    logic [`PERF_CNT_WIDTH-1:0] stall_sum;
    errs = 0;
    for (a = 0; a <= num_addr; a++) begin
      next_cycle();
      // Data for the address driven one cycle earlier
      if (a > 0) begin
        exp         = expected_count(a - 1);
        seen[a - 1] = rd_data;
        total_checks++;
        assert (rd_data === exp) else begin
          $display("CHECK FAILED %s addr %0d expected %0d actual %0d",
                   name, a - 1, exp, rd_data);
          errs++;
        end
      end
      apply(idle_vec());
      if (a < num_addr) rd_addr = a[`PERF_ADDR_WIDTH-1:0];
    end
    // Each non-retiring enabled cycle sits in exactly one stall counter
    stall_sum = '0;
    for (a = stall_base; a < PERF_STALL_CNT; a++) begin
      stall_sum += seen[a];
    end
    exp = exp_cnt[0] - exp_cnt[1];
    total_checks++;
    assert (stall_sum === exp) else begin
      $display("CHECK FAILED %s stall sum expected %0d actual %0d",
               name, exp, stall_sum);
      errs++;
    end
    total_errs += errs;
    $display("test %s: %0d errors", name, errs);
  endtask

  initial begin
    int pad;
    clk     = 1'b0;
    reset   = 1'b1;
    rd_addr = '0;
    drive_inputs(idle_vec());
    clear_model();
    load_vectors(load_ok);
    if (load_ok) begin
      limit = reset_cyc + n_stim + n_tests * test_cyc + 64;
      repeat (reset_cyc) @(posedge clk);
      #10;
      reset = 1'b0;
      apply(idle_vec());
      for (int i = 0; i < vec_q.size(); i++) begin
        if (vec_q[i].is_mark) begin
          check_test(name_q[i]);
          // Random idle gap before the next test
          pad = $unsigned($random(seed)) % 4;
          repeat (pad) begin
            next_cycle();
            apply(idle_vec());
          end
        end else begin
          next_cycle();
          apply(vec_q[i]);
        end
      end
    end
    $display("%0d tests, %0d checks, %0d failures", n_tests, total_checks, total_errs);
    if (load_ok && total_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/perf_vectors.txt
# S freeze en core mem, binary; core = instret icv icr dcv dcr br_ovr fe_cmd mispred ctl data struct dc_miss
# mem = l2_cmd_v serving_ic serving_dc serving_evict; T name checks all counters after the lines above it
T reset_zero
S 0 1 111110000000 0000
S 0 1 111110000000 0000
S 0 1 011110000000 0000
S 0 0 111110000000 0000
S 0 0 011110000000 0000
S 0 1 110110000000 0000
T count_enable
S 0 1 000011111111 0000
S 0 1 001011111111 0000
S 0 1 001010111111 0000
S 0 1 001010011111 0000
S 0 1 001010001111 0000
S 0 1 001010000111 0000
S 0 1 001010000011 0000
S 0 1 001010000001 0000
S 0 1 001010000000 0000
S 0 1 101011111111 0000
T stall_priority
S 0 1 111110000000 0000
S 0 1 110110000000 0000
S 0 1 110110000000 0000
S 0 1 111100000000 0000
S 0 1 110100000000 0000
S 0 0 111110000000 0000
S 0 0 110100000000 0000
S 0 1 110100000000 0000
S 0 1 111110000000 0000
T cache_events
S 0 1 111110000000 1100
S 0 1 111110000000 0100
S 0 1 111110000000 1010
S 0 1 111110000000 0010
S 0 1 111110000000 1011
S 0 1 111110000000 0011
S 0 1 111110000000 1000
S 0 1 111110000000 0001
S 0 0 111110000000 1100
T l2_classify
S 0 1 011110000000 0000
S 1 1 111110000000 1100
S 0 1 111110000000 0000
S 0 1 001010000001 0100
T freeze_clear
S 0 1 110110000000 0000
S 1 0 111110000000 0000
T freeze_idle

//--- sources.f
+incdir+hw
hw/perf_pkg.sv
hw/perf_stall_classifier.sv
hw/perf_mem_event_detect.sv
hw/perf_counter_bank.sv
hw/perf_readout.sv
hw/perf_profiler_top.sv
dv/tb_perf_profiler.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_perf_profiler
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "no result found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
